// ==== project.f ====
rtl/axi_dwc_pkg.sv
rtl/dwc_cmd_pkg.sv
rtl/axi_aw_if.sv
rtl/axi_b_if.sv
rtl/dwc_cmd_fifo.sv
rtl/dwc_aw_splitter.sv
rtl/dwc_bresp_ctrl.sv
rtl/dwc_write_resp_top.sv
test/dwc_write_resp_props.sv
test/tb_dwc_write_resp.sv

// ==== Makefile ====
# Verilator simulation of the write response bookkeeping
VERILATOR ?= verilator
TOP       ?= tb_dwc_write_resp
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

# The run passes only if the log holds the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_dwc_write_resp.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dwc_write_resp
	import axi_dwc_pkg::*;
();

	// Cycles any single wait may take before it gives up
	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
	} aw_rec_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [1:0]        resp;
		logic [USER_W-1:0] user;
	} b_rec_t;

	logic              aclk;
	logic              reset;
	logic [ID_W-1:0]   m_awid;
	logic [ADDR_W-1:0] m_awaddr;
	logic [LEN_W-1:0]  m_awlen;
	logic              m_awvalid;
	logic              m_awready;
	logic [ID_W-1:0]   s_awid;
	logic [ADDR_W-1:0] s_awaddr;
	logic [LEN_W-1:0]  s_awlen;
	logic              s_awvalid;
	logic              s_awready;
	logic [ID_W-1:0]   s_bid;
	axi_resp_t         s_bresp;
	logic [USER_W-1:0] s_buser;
	logic              s_bvalid;
	logic              s_bready;
	logic [ID_W-1:0]   m_bid;
	axi_resp_t         m_bresp;
	logic [USER_W-1:0] m_buser;
	logic              m_bvalid;
	logic              m_bready;

	// Reference bursts and responses against what the monitors saw
	aw_rec_t exp_aw [$];
	aw_rec_t got_aw [$];
	b_rec_t  exp_b [$];
	b_rec_t  got_b [$];

	int errors = 0;
	int tests_run = 0;
	logic [7:0] lfsr_state = 8'd53;

	dwc_write_resp_top dwc_write_resp_top_inst (.*);

	always #4 aclk = ~aclk;

	//////////////////////////////////////////////////
	// Slave side monitors
	//////////////////////////////////////////////////

	// Inputs change only at rising edges, so the falling edge sees the
	// values that the next rising edge will transfer
	always @(negedge aclk) begin
		if (s_awvalid && s_awready) begin
			got_aw.push_back(aw_rec_t'{id: s_awid, addr: s_awaddr, len: s_awlen});
		end
		if (m_bvalid && m_bready) begin
			got_b.push_back(b_rec_t'{id: m_bid, resp: m_bresp, user: m_buser});
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Taps 8, 6, 5, 4 give a maximal length sequence
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// One LFSR step per bit handed out
	task automatic take_bits(output logic [1:0] val);
		for (int i = 0; i < 2; i++) begin
			val[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_aw_accept();
		int cycles;
		cycles = 0;
		do begin
			@(posedge aclk);
			cycles++;
		end while (!m_awready && cycles < WAIT_LIMIT);
		assert (m_awready) else begin
			$display("At %0t ns the master write address was never accepted", $time);
			errors++;
		end
		m_awvalid <= 1'b0;
	endtask

	task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
			input logic [LEN_W-1:0] len);
		@(posedge aclk);
		m_awid    <= id;
		m_awaddr  <= addr;
		m_awlen   <= len;
		m_awvalid <= 1'b1;
		wait_aw_accept();
	endtask

	// Wide beats are ceil((len + 1) / 2), cut into bursts of at most 16
	// with each burst 128 bytes after the one before
	task automatic add_expected_bursts(input logic [ID_W-1:0] id,
			input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
			output int bursts);
		int wide;
		int beats;
		logic [ADDR_W-1:0] next_addr;
		wide = (int'(len) + 2) / 2;
		next_addr = addr;
		bursts = 0;
		while (wide > 0) begin
			beats = (wide > 16) ? 16 : wide;
			exp_aw.push_back(aw_rec_t'{id: id, addr: next_addr, len: LEN_W'(beats - 1)});
			next_addr = next_addr + 32'd128;
			wide -= beats;
			bursts++;
		end
	endtask

	task automatic wait_aw_count(input int n);
		int cycles;
		cycles = 0;
		while (got_aw.size() < n && cycles < WAIT_LIMIT) begin
			@(posedge aclk);
			cycles++;
		end
		assert (got_aw.size() >= n) else begin
			$display("At %0t ns only %0d of %0d slave bursts appeared", $time,
				got_aw.size(), n);
			errors++;
		end
	endtask

	task automatic wait_b_count(input int n);
		int cycles;
		cycles = 0;
		while (got_b.size() < n && cycles < WAIT_LIMIT) begin
			@(posedge aclk);
			cycles++;
		end
		assert (got_b.size() >= n) else begin
			$display("At %0t ns only %0d of %0d master responses appeared", $time,
				got_b.size(), n);
			errors++;
		end
	endtask

	task automatic compare_aw_queue();
		compare_value("slave AW count", 32'(got_aw.size()), 32'(exp_aw.size()));
		foreach (exp_aw[i]) begin
			if (i < got_aw.size()) begin
				compare_value("s_awid", 32'(got_aw[i].id), 32'(exp_aw[i].id));
				compare_value("s_awaddr", got_aw[i].addr, exp_aw[i].addr);
				compare_value("s_awlen", 32'(got_aw[i].len), 32'(exp_aw[i].len));
			end
		end
	endtask

	task automatic compare_b_queue();
		compare_value("master B count", 32'(got_b.size()), 32'(exp_b.size()));
		foreach (exp_b[i]) begin
			if (i < got_b.size()) begin
				compare_value("m_bid", 32'(got_b[i].id), 32'(exp_b[i].id));
				compare_value("m_bresp", 32'(got_b[i].resp), 32'(exp_b[i].resp));
				compare_value("m_buser", 32'(got_b[i].user), 32'(exp_b[i].user));
			end
		end
	endtask

	// Slave model response, an absorbed one must never show on the master side
	task automatic send_b(input logic [ID_W-1:0] id, input logic [1:0] code,
			input logic [USER_W-1:0] user, input logic last);
		int cycles;
		@(posedge aclk);
		s_bid    <= id;
		s_bresp  <= axi_resp_t'(code);
		s_buser  <= user;
		s_bvalid <= 1'b1;
		cycles = 0;
		do begin
			@(posedge aclk);
			cycles++;
			if (!last) begin
				compare_value("m_bvalid", 32'(m_bvalid), 32'd0);
			end
		end while (!s_bready && cycles < WAIT_LIMIT);
		assert (s_bready) else begin
			$display("At %0t ns the slave response was never accepted", $time);
			errors++;
		end
		s_bvalid <= 1'b0;
	endtask

	// Answers every slave burst of one master burst, the worst code is expected
	task automatic answer_bursts(input logic [ID_W-1:0] id, input int bursts);
		logic [1:0] code;
		logic [1:0] user;
		logic [1:0] worst;
		worst = 2'd0;
		user = 2'd0;
		for (int i = 0; i < bursts; i++) begin
			take_bits(code);
			take_bits(user);
			if (code > worst) begin
				worst = code;
			end
			send_b(id, code, user, i == bursts - 1);
		end
		exp_b.push_back(b_rec_t'{id: id, resp: worst, user: user});
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic clear_queues();
		exp_aw.delete();
		got_aw.delete();
		exp_b.delete();
		got_b.delete();
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic reset_state_check();
		int errs;
		errs = errors;
		@(posedge aclk);
		compare_value("m_awready", 32'(m_awready), 32'd1);
		compare_value("s_awvalid", 32'(s_awvalid), 32'd0);
		compare_value("m_bvalid", 32'(m_bvalid), 32'd0);
		compare_value("s_bready", 32'(s_bready), 32'd0);
		report_test("reset state", errs);
	endtask

	// Ten narrow beats make a single five beat slave burst
	task automatic short_burst();
		int errs;
		int bursts;
		errs = errors;
		clear_queues();
		send_aw(4'd3, 32'h0000_1000, 8'd9);
		add_expected_bursts(4'd3, 32'h0000_1000, 8'd9, bursts);
		wait_aw_count(bursts);
		compare_aw_queue();
		answer_bursts(4'd3, bursts);
		wait_b_count(1);
		compare_b_queue();
		report_test("short burst", errs);
	endtask

	// A hundred narrow beats split into 16, 16, 16 and 2 wide beats
	// The slave holds off the first burst for a few cycles, so its address must wait
	task automatic split_burst();
		int errs;
		int bursts;
		errs = errors;
		clear_queues();
		s_awready <= 1'b0;
		send_aw(4'd5, 32'h0000_2000, 8'd99);
		add_expected_bursts(4'd5, 32'h0000_2000, 8'd99, bursts);
		repeat (3) begin
			@(posedge aclk);
			compare_value("s_awvalid", 32'(s_awvalid), 32'd1);
		end
		s_awready <= 1'b1;
		wait_aw_count(bursts);
		compare_aw_queue();
		answer_bursts(4'd5, bursts);
		wait_b_count(1);
		compare_b_queue();
		report_test("split burst", errs);
	endtask

	// Two slave bursts, the last response is held off by the master
	task automatic bready_backpressure();
		int errs;
		int bursts;
		int cycles;
		logic [1:0] code0;
		logic [1:0] code1;
		logic [1:0] user;
		logic [1:0] worst;
		errs = errors;
		clear_queues();
		m_bready <= 1'b0;
		send_aw(4'd9, 32'h0000_3000, 8'd33);
		add_expected_bursts(4'd9, 32'h0000_3000, 8'd33, bursts);
		wait_aw_count(bursts);
		compare_aw_queue();
		take_bits(code0);
		take_bits(user);
		send_b(4'd9, code0, user, 1'b0);
		take_bits(code1);
		take_bits(user);
		worst = (code1 > code0) ? code1 : code0;
		@(posedge aclk);
		s_bid    <= 4'd9;
		s_bresp  <= axi_resp_t'(code1);
		s_buser  <= user;
		s_bvalid <= 1'b1;
		repeat (6) begin
			@(posedge aclk);
			compare_value("s_bready", 32'(s_bready), 32'd0);
			compare_value("m_bvalid", 32'(m_bvalid), 32'd1);
			compare_value("m_bid", 32'(m_bid), 32'd9);
			compare_value("m_bresp", 32'(m_bresp), 32'(worst));
		end
		m_bready <= 1'b1;
		cycles = 0;
		do begin
			@(posedge aclk);
			cycles++;
		end while (!s_bready && cycles < WAIT_LIMIT);
		assert (s_bready) else begin
			$display("At %0t ns the held response never completed", $time);
			errors++;
		end
		s_bvalid <= 1'b0;
		exp_b.push_back(b_rec_t'{id: 4'd9, resp: worst, user: user});
		// Extra cycles so that a repeated response would be caught
		repeat (4) @(posedge aclk);
		compare_b_queue();
		report_test("bready back-pressure", errs);
	endtask

	// Four records fill the FIFO, a fifth master burst waits for a pop
	task automatic fifo_full_stall();
		int errs;
		int bursts;
		errs = errors;
		clear_queues();
		for (int i = 1; i <= 4; i++) begin
			send_aw(ID_W'(i), 32'h0000_4000 + 32'(i) * 32'h100, 8'd1);
			add_expected_bursts(ID_W'(i), 32'h0000_4000 + 32'(i) * 32'h100, 8'd1, bursts);
		end
		wait_aw_count(4);
		@(posedge aclk);
		m_awid    <= 4'd6;
		m_awaddr  <= 32'h0000_5000;
		m_awlen   <= 8'd1;
		m_awvalid <= 1'b1;
		repeat (4) begin
			@(posedge aclk);
			compare_value("m_awready", 32'(m_awready), 32'd0);
		end
		answer_bursts(4'd1, 1);
		wait_aw_accept();
		add_expected_bursts(4'd6, 32'h0000_5000, 8'd1, bursts);
		wait_aw_count(5);
		compare_aw_queue();
		answer_bursts(4'd2, 1);
		answer_bursts(4'd3, 1);
		answer_bursts(4'd4, 1);
		answer_bursts(4'd6, 1);
		wait_b_count(5);
		compare_b_queue();
		report_test("FIFO full stall", errs);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		aclk      = 1'b0;
		reset     = 1'b1;
		m_awid    = '0;
		m_awaddr  = '0;
		m_awlen   = '0;
		m_awvalid = 1'b0;
		s_awready = 1'b1;
		s_bid     = '0;
		s_bresp   = OKAY;
		s_buser   = '0;
		s_bvalid  = 1'b0;
		m_bready  = 1'b1;
		repeat (10) @(posedge aclk);
		reset <= 1'b0;
		reset_state_check();
		short_burst();
		split_burst();
		bready_backpressure();
		fifo_full_stall();
		repeat (2) @(posedge aclk);
		errors += dwc_write_resp_top_inst.props_inst.fail_count;
		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/dwc_write_resp_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module dwc_write_resp_props
	import axi_dwc_pkg::*;
(
	input logic              aclk,
	input logic              reset,
	input logic [ID_W-1:0]   m_bid,
	input axi_resp_t         m_bresp,
	input logic [USER_W-1:0] m_buser,
	input logic              m_bvalid,
	input logic              m_bready,
	input logic [ID_W-1:0]   s_awid,
	input logic [ADDR_W-1:0] s_awaddr,
	input logic [LEN_W-1:0]  s_awlen,
	input logic              s_awvalid,
	input logic              s_awready,
	input logic              m_awready,
	input logic              cmd_full
);

	// Read back by the testbench at the end of the run
	int fail_count = 0;

	//////////////////////////////////////////////////
	// Channel stability
	//////////////////////////////////////////////////

	// A stalled master response keeps its valid and its whole payload
	assert property (@(posedge aclk) disable iff (reset)
		m_bvalid && !m_bready |=>
		m_bvalid && $stable(m_bid) && $stable(m_bresp) && $stable(m_buser))
	else begin
		$error("master B dropped or changed before bready");
		fail_count++;
	end

	// Same rule for each slave burst address
	assert property (@(posedge aclk) disable iff (reset)
		s_awvalid && !s_awready |=>
		s_awvalid && $stable(s_awid) && $stable(s_awaddr) && $stable(s_awlen))
	else begin
		$error("slave AW dropped or changed before awready");
		fail_count++;
	end

	// No new master burst may be taken without room for its record
	assert property (@(posedge aclk) disable iff (reset) !(m_awready && cmd_full))
	else begin
		$error("master awready high with the command FIFO full");
		fail_count++;
	end

endmodule

// Attach to the top level, cmd_full is the top's internal wire
bind dwc_write_resp_top dwc_write_resp_props props_inst (.*);

`default_nettype wire

// ==== rtl/dwc_write_resp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dwc_write_resp_top
	import axi_dwc_pkg::*;
	import dwc_cmd_pkg::*;
(
	input  logic              aclk,
	input  logic              reset,

	// Master write address, 32-bit side
	input  logic [ID_W-1:0]   m_awid,
	input  logic [ADDR_W-1:0] m_awaddr,
	input  logic [LEN_W-1:0]  m_awlen,
	input  logic              m_awvalid,
	output logic              m_awready,

	// Slave write address, 64-bit side
	output logic [ID_W-1:0]   s_awid,
	output logic [ADDR_W-1:0] s_awaddr,
	output logic [LEN_W-1:0]  s_awlen,
	output logic              s_awvalid,
	input  logic              s_awready,

	// Slave write response
	input  logic [ID_W-1:0]   s_bid,
	input  axi_resp_t         s_bresp,
	input  logic [USER_W-1:0] s_buser,
	input  logic              s_bvalid,
	output logic              s_bready,

	// Master write response
	output logic [ID_W-1:0]   m_bid,
	output axi_resp_t         m_bresp,
	output logic [USER_W-1:0] m_buser,
	output logic              m_bvalid,
	input  logic              m_bready
);

	axi_aw_if m_aw_bus ();
	axi_aw_if s_aw_bus ();
	axi_b_if  s_b_bus ();
	axi_b_if  m_b_bus ();

	// Command path from splitter through the FIFO to the response controller
	logic   cmd_push;
	b_cmd_t cmd_data;
	logic   cmd_full;
	logic   cmd_pop;
	b_cmd_t cmd_head;
	logic   cmd_empty;

	//////////////////////////////////////////////////
	// Port to bus mapping
	//////////////////////////////////////////////////

	assign m_aw_bus.awid    = m_awid;
	assign m_aw_bus.awaddr  = m_awaddr;
	assign m_aw_bus.awlen   = m_awlen;
	assign m_aw_bus.awvalid = m_awvalid;
	assign m_awready        = m_aw_bus.awready;

	assign s_awid           = s_aw_bus.awid;
	assign s_awaddr         = s_aw_bus.awaddr;
	assign s_awlen          = s_aw_bus.awlen;
	assign s_awvalid        = s_aw_bus.awvalid;
	assign s_aw_bus.awready = s_awready;

	assign s_b_bus.bid      = s_bid;
	assign s_b_bus.bresp    = s_bresp;
	assign s_b_bus.buser    = s_buser;
	assign s_b_bus.bvalid   = s_bvalid;
	assign s_bready         = s_b_bus.bready;

	assign m_bid            = m_b_bus.bid;
	assign m_bresp          = m_b_bus.bresp;
	assign m_buser          = m_b_bus.buser;
	assign m_bvalid         = m_b_bus.bvalid;
	assign m_b_bus.bready   = m_bready;

	dwc_aw_splitter splitter_inst (
		.aclk     (aclk),
		.reset    (reset),
		.m_aw     (m_aw_bus.dst),
		.s_aw     (s_aw_bus.src),
		.cmd_push (cmd_push),
		.cmd_data (cmd_data),
		.cmd_full (cmd_full)
	);

	dwc_cmd_fifo cmd_fifo_inst (
		.aclk      (aclk),
		.reset     (reset),
		.cmd_push  (cmd_push),
		.cmd_data  (cmd_data),
		.cmd_pop   (cmd_pop),
		.cmd_head  (cmd_head),
		.cmd_full  (cmd_full),
		.cmd_empty (cmd_empty)
	);

	dwc_bresp_ctrl bresp_ctrl_inst (
		.aclk      (aclk),
		.reset     (reset),
		.s_b       (s_b_bus.dst),
		.m_b       (m_b_bus.src),
		.cmd_head  (cmd_head),
		.cmd_empty (cmd_empty),
		.cmd_pop   (cmd_pop)
	);

endmodule

`default_nettype wire

// ==== rtl/dwc_bresp_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dwc_bresp_ctrl
	import axi_dwc_pkg::*;
	import dwc_cmd_pkg::*;
(
	input  logic   aclk,
	input  logic   reset,
	axi_b_if.dst   s_b,
	axi_b_if.src   m_b,
	input  b_cmd_t cmd_head,
	input  logic   cmd_empty,
	output logic   cmd_pop
);

	// Responses still to absorb for the head record, valid once head_loaded
	logic [SPLIT_W-1:0] absorb_left;
	logic               head_loaded;
	// Worst code seen so far among the absorbed responses
	axi_resp_t          worst_resp;

	logic [SPLIT_W-1:0] left_now;
	logic               absorbing;
	logic               final_phase;
	logic               s_hs;
	axi_resp_t          merged_resp;

	//////////////////////////////////////////////////
	// Head record tracking
	//////////////////////////////////////////////////

	// A fresh head record supplies the countdown directly
	// so the first response is taken without a bubble
	assign left_now = head_loaded ? absorb_left : cmd_head.split_cnt;

	// Intermediate slave responses are eaten here, the master never sees them
	assign absorbing   = !cmd_empty && (left_now != '0);
	assign final_phase = !cmd_empty && (left_now == '0);

	// Higher code wins
	assign merged_resp = (s_b.bresp > worst_resp) ? s_b.bresp : worst_resp;

	//////////////////////////////////////////////////
	// Channel steering
	//////////////////////////////////////////////////

	// Last response passes straight through, no register in the valid or ready path
	assign s_b.bready = absorbing || (final_phase && m_b.bready);
	assign m_b.bvalid = final_phase && s_b.bvalid;
	assign m_b.bid    = cmd_head.id;
	assign m_b.bresp  = merged_resp;
	// User bits come from the last slave response only
	assign m_b.buser  = s_b.buser;

	assign s_hs    = absorbing && s_b.bvalid;
	assign cmd_pop = m_b.bvalid && m_b.bready;

	always_ff @(posedge aclk) begin
		if (reset) begin
			head_loaded <= 1'b0;
			absorb_left <= '0;
			worst_resp  <= OKAY;
		end else if (cmd_pop) begin
			// Next record starts clean
			head_loaded <= 1'b0;
			worst_resp  <= OKAY;
		end else if (s_hs) begin
			head_loaded <= 1'b1;
			absorb_left <= left_now - 1'b1;
			worst_resp  <= merged_resp;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dwc_aw_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dwc_aw_splitter
	import axi_dwc_pkg::*;
	import dwc_cmd_pkg::*;
(
	input  logic   aclk,
	input  logic   reset,
	axi_aw_if.dst  m_aw,
	axi_aw_if.src  s_aw,
	output logic   cmd_push,
	output b_cmd_t cmd_data,
	input  logic   cmd_full
);

	typedef enum logic {
		SPLIT_IDLE,
		SPLIT_ISSUE
	} split_state_t;

	split_state_t state;

	// Burst being split, captured on the master handshake
	logic [ID_W-1:0]    cur_id;
	logic [ADDR_W-1:0]  base_addr;
	logic [SPLIT_W-1:0] burst_idx;
	logic [LEN_W-1:0]   beats_left;

	logic [LEN_W-1:0] wide_beats;
	logic             m_hs;
	logic             s_hs;
	logic             last_burst;

	//////////////////////////////////////////////////
	// Master side and command record
	//////////////////////////////////////////////////

	// Only take a new burst when idle and there is room for its record
	assign m_aw.awready = (state == SPLIT_IDLE) && !cmd_full;
	assign m_hs         = m_aw.awvalid && m_aw.awready;

	// Ceiling of (awlen + 1) / 2 equals awlen / 2 + 1
	assign wide_beats = LEN_W'(m_aw.awlen / UP_RATIO) + LEN_W'(1);

	// The record goes out on the handshake cycle itself
	assign cmd_push           = m_hs;
	assign cmd_data.id        = m_aw.awid;
	assign cmd_data.split_cnt = SPLIT_W'((wide_beats - LEN_W'(1)) / SLAVE_MAX_BEATS);

	//////////////////////////////////////////////////
	// Slave side
	//////////////////////////////////////////////////

	// The remainder fits in one burst, so this is the last of the split
	assign last_burst = (beats_left <= LEN_W'(SLAVE_MAX_BEATS));

	assign s_aw.awvalid = (state == SPLIT_ISSUE);
	assign s_aw.awid    = cur_id;
	// Each burst starts one full slave burst worth of bytes after the previous
	assign s_aw.awaddr  = base_addr + ADDR_W'(burst_idx) * ADDR_W'(BURST_STRIDE);
	assign s_aw.awlen   = last_burst ? beats_left - LEN_W'(1) : LEN_W'(SLAVE_MAX_BEATS - 1);
	assign s_hs         = s_aw.awvalid && s_aw.awready;

	// Sequencing
	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= SPLIT_IDLE;
		end else begin
			case (state)
				SPLIT_IDLE: begin
					if (m_hs) begin
						state <= SPLIT_ISSUE;
					end
				end
				SPLIT_ISSUE: begin
					// Valid stays up between bursts, the payload moves on at the edge
					if (s_hs && last_burst) begin
						state <= SPLIT_IDLE;
					end
				end
				default: state <= SPLIT_IDLE;
			endcase
		end
	end

	// Burst payload, it only changes on a handshake so it is stable while valid
	always_ff @(posedge aclk) begin
		if (m_hs) begin
			cur_id     <= m_aw.awid;
			base_addr  <= m_aw.awaddr;
			beats_left <= wide_beats;
			burst_idx  <= '0;
		end else if (s_hs && !last_burst) begin
			beats_left <= beats_left - LEN_W'(SLAVE_MAX_BEATS);
			burst_idx  <= burst_idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dwc_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dwc_cmd_fifo
	import dwc_cmd_pkg::*;
(
	input  logic   aclk,
	input  logic   reset,
	input  logic   cmd_push,
	input  b_cmd_t cmd_data,
	input  logic   cmd_pop,
	output b_cmd_t cmd_head,
	output logic   cmd_full,
	output logic   cmd_empty
);

	// Record storage, written at wr_ptr and read at rd_ptr
	b_cmd_t mem [CMD_FIFO_DEPTH];

	logic [CMD_PTR_W-1:0] wr_ptr;
	logic [CMD_PTR_W-1:0] rd_ptr;
	logic [CMD_CNT_W-1:0] count;

	logic push_ok;
	logic pop_ok;

	// Requests against a full or empty buffer are dropped here
	assign push_ok = cmd_push && !cmd_full;
	assign pop_ok  = cmd_pop && !cmd_empty;

	assign cmd_full  = (count == CMD_CNT_W'(CMD_FIFO_DEPTH));
	assign cmd_empty = (count == '0);

	// First word fall through, so the head is visible the cycle after the push
	assign cmd_head = mem[rd_ptr];

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge aclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				// Wrap explicitly so a depth that is not a power of two also works
				wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop in the same cycle leave the count unchanged
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Record array
	always_ff @(posedge aclk) begin
		if (push_ok) begin
			mem[wr_ptr] <= cmd_data;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/axi_b_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Write response channel
interface axi_b_if
	import axi_dwc_pkg::*;
();

	logic [ID_W-1:0]   bid;
	axi_resp_t         bresp;
	logic [USER_W-1:0] buser;
	logic              bvalid;
	logic              bready;

	// Side that returns responses
	modport src (
		output bid,
		output bresp,
		output buser,
		output bvalid,
		input  bready
	);

	// Side that takes responses
	modport dst (
		input  bid,
		input  bresp,
		input  buser,
		input  bvalid,
		output bready
	);

endinterface

`default_nettype wire

// ==== rtl/axi_aw_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Write address channel, only the fields this converter looks at
interface axi_aw_if
	import axi_dwc_pkg::*;
();

	logic [ID_W-1:0]   awid;
	logic [ADDR_W-1:0] awaddr;
	logic [LEN_W-1:0]  awlen;
	logic              awvalid;
	logic              awready;

	// Side that issues addresses
	modport src (
		output awid,
		output awaddr,
		output awlen,
		output awvalid,
		input  awready
	);

	// Side that accepts addresses
	modport dst (
		input  awid,
		input  awaddr,
		input  awlen,
		input  awvalid,
		output awready
	);

endinterface

`default_nettype wire

// ==== rtl/dwc_cmd_pkg.sv ====
`default_nettype none

package dwc_cmd_pkg;

	import axi_dwc_pkg::*;

	//////////////////////////////////////////////////
	// Up-conversion limits
	//////////////////////////////////////////////////

	// Two 32-bit master beats pack into one 64-bit slave beat
	localparam int UP_RATIO = 2;

	// Longest burst issued on the slave port
	localparam int SLAVE_MAX_BEATS = 16;

	// Bytes moved by one slave beat
	localparam int WIDE_BYTES = 8;

	// Address step between consecutive slave bursts of one split
	localparam int BURST_STRIDE = SLAVE_MAX_BEATS * WIDE_BYTES;

	// Command FIFO sizing, one record per outstanding master burst
	localparam int CMD_FIFO_DEPTH = 4;
	localparam int CMD_PTR_W = $clog2(CMD_FIFO_DEPTH);
	localparam int CMD_CNT_W = $clog2(CMD_FIFO_DEPTH + 1);

	// A 256-beat master burst gives 128 wide beats, that is 8 slave bursts
	localparam int SPLIT_W = 3;

	//////////////////////////////////////////////////
	// Command record
	//////////////////////////////////////////////////

	// One record per master burst, split_cnt is the slave burst count minus one
	// and so also the number of slave responses to absorb
	typedef struct packed {
		logic [ID_W-1:0]    id;
		logic [SPLIT_W-1:0] split_cnt;
	} b_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/axi_dwc_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// AXI bus field widths shared by both ports
//////////////////////////////////////////////////

package axi_dwc_pkg;

	// Transaction ID width on both the master and the slave side
	localparam int ID_W = 4;

	// Byte address width
	localparam int ADDR_W = 32;

	// AxLEN field width, a burst carries AxLEN + 1 beats
	localparam int LEN_W = 8;

	// B channel user sideband width
	localparam int USER_W = 2;

	//////////////////////////////////////////////////
	// Write response codes
	//////////////////////////////////////////////////

	// The encoding grows with severity, so the numerically highest code
	// is also the worst one when several responses are merged
	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		EXOKAY = 2'd1,
		SLVERR = 2'd2,
		DECERR = 2'd3
	} axi_resp_t;

endpackage

`default_nettype wire
